/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// ========================================================================
	// 8N1 framing
	// ========================================================================
	localparam int CLKS_PER_BIT = 16;                     // short bit for fast sim
	localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);   // bit-period counter width
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;       // start bit mid-point
	localparam int FRAME_BITS   = 10;                     // start + 8 data + stop

	// one character on the line
	typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

/* hw/matrix_pkg.sv */
`default_nettype none

package matrix_pkg;

	// ========================================================================
	// matrix limits and record
	// ========================================================================
	localparam int MAX_DIM    = 5;                     // rows or cols, 1..5
	localparam int MAX_ELEMS  = MAX_DIM * MAX_DIM;
	localparam int ELEM_IDX_W = $clog2(MAX_ELEMS);     // 5 bits, 0..24

	typedef logic [2:0] dim_t;
	typedef logic [7:0] elem_t;                        // value 0..9

	// row-major, element (r,c) sits at r*cols+c
	typedef struct packed {
		dim_t                  rows;
		dim_t                  cols;
		elem_t [MAX_ELEMS-1:0] elems;
	} matrix_t;                                        // 206 bits

	// ========================================================================
	// store and status LED
	// ========================================================================
	localparam int NUM_SLOTS       = 2;
	localparam int LED_HOLD_CYCLES = 4096;            // activity stretch length
	localparam int HOLD_CNT_W      = $clog2(LED_HOLD_CYCLES);

	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;

	// ascii codes seen by parser and printer
	localparam logic [7:0] ASCII_ZERO  = 8'h30;
	localparam logic [7:0] ASCII_SPACE = 8'h20;
	localparam logic [7:0] ASCII_CR    = 8'h0d;
	localparam logic [7:0] ASCII_LF    = 8'h0a;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import uart_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  wire   uart_rxd,
	output logic  rx_done,     // one-cycle strobe
	output byte_t rx_data      // valid with rx_done
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	logic                 rxd_meta;
	logic                 rxd_sync;
	rx_state_t            state;
	logic [BIT_CNT_W-1:0] cnt;          // clocks inside current bit
	logic [2:0]           bit_idx;      // data bit, lsb first
	logic                 bit_mid;

	// two-flop synchroniser, idles high like the line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign bit_mid = (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));   // one bit after last sample

	// ========================================================================
	// frame FSM
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			cnt     <= cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (!rxd_sync)
						state <= RX_START;   // falling edge
				end
				RX_START: if (cnt == BIT_CNT_W'(HALF_BIT - 1)) begin
					cnt   <= '0;
					state <= rxd_sync ? RX_IDLE : RX_DATA;   // high again means glitch
				end
				RX_DATA: if (bit_mid) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (bit_mid) begin
					rx_done <= rxd_sync;     // low stop bit, frame dropped
					state   <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data shift register, lsb arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_mid)
			rx_data <= {rxd_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import uart_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  wire   tx_en,       // strobe, only taken while idle
	input  byte_t tx_data,
	output wire   uart_txd,
	output logic  tx_busy
);

	logic [BIT_CNT_W-1:0]  cnt;
	logic [3:0]            bit_idx;     // 0..9 over the frame
	logic [FRAME_BITS-1:0] frame;       // stop, data, start; shifted out from bit 0
	logic                  bit_end;

	assign bit_end = (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// bit timing, busy covers the full stop bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			cnt     <= '0;
			bit_idx <= '0;
			if (tx_en)
				tx_busy <= 1'b1;
		end else if (bit_end) begin
			cnt     <= '0;
			bit_idx <= bit_idx + 1'b1;
			if (bit_idx == 4'(FRAME_BITS - 1))
				tx_busy <= 1'b0;     // stop bit done
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// frame shift register
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_en)
			frame <= {1'b1, tx_data, 1'b0};
		else if (tx_busy && bit_end)
			frame <= {1'b1, frame[FRAME_BITS-1:1]};
	end

	assign uart_txd = tx_busy ? frame[0] : 1'b1;   // line idles high

endmodule

`default_nettype wire

/* hw/matrix_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_parser
	import uart_pkg::*;
	import matrix_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  wire     input_en,      // level, low resets the parse
	input  wire     rx_done,
	input  byte_t   rx_data,
	output logic    parse_done,    // strobe with the complete record
	output matrix_t parsed,
	output logic    parse_error    // held until next good matrix
);

	typedef enum logic [1:0] {P_ROWS, P_COLS, P_ELEMS} parse_state_t;

	parse_state_t          state;
	logic [ELEM_IDX_W-1:0] elem_idx;
	logic [ELEM_IDX_W-1:0] n_elems;    // rows * cols, at most 25
	byte_t                 digit;
	logic                  is_digit;
	logic                  is_blank;
	logic                  dim_ok;
	logic                  take;

	// character classes
	assign digit    = rx_data - ASCII_ZERO;
	assign is_digit = (rx_data >= ASCII_ZERO) && (rx_data <= ASCII_ZERO + 8'd9);
	assign is_blank = (rx_data == ASCII_SPACE) || (rx_data == ASCII_CR) ||
	                  (rx_data == ASCII_LF);
	assign dim_ok   = (digit >= 8'd1) && (digit <= 8'(MAX_DIM));
	assign n_elems  = parsed.rows * parsed.cols;
	assign take     = input_en && rx_done && is_digit;

	// ========================================================================
	// parse FSM
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= P_ROWS;
			elem_idx    <= '0;
			parse_done  <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			parse_done <= 1'b0;
			if (!input_en) begin
				state <= P_ROWS;               // bytes ignored
			end else if (rx_done && !is_blank) begin
				if (!is_digit) begin
					parse_error <= 1'b1;
					state       <= P_ROWS;
				end else begin
					case (state)
						P_ROWS: begin
							if (dim_ok)
								state <= P_COLS;
							else
								parse_error <= 1'b1;   // 0 or > MAX_DIM
						end
						P_COLS: begin
							elem_idx <= '0;
							if (dim_ok) begin
								state <= P_ELEMS;
							end else begin
								parse_error <= 1'b1;
								state       <= P_ROWS;
							end
						end
						P_ELEMS: begin
							if (elem_idx == n_elems - 1'b1) begin
								parse_done  <= 1'b1;   // last element in
								parse_error <= 1'b0;
								state       <= P_ROWS;
							end else begin
								elem_idx <= elem_idx + 1'b1;
							end
						end
						default: state <= P_ROWS;
					endcase
				end
			end
		end
	end

	// record payload, elements cleared when a new matrix starts
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				P_ROWS: parsed.rows <= dim_t'(digit);
				P_COLS: begin
					parsed.cols  <= dim_t'(digit);
					parsed.elems <= '0;
				end
				P_ELEMS: parsed.elems[elem_idx] <= elem_t'(digit);
				default: parsed.rows <= parsed.rows;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/matrix_store.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_store
	import matrix_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        parse_done,    // write strobe
	input  matrix_t    parsed,
	input  slot_t      print_slot,    // read address, latched by the printer
	input  wire        print_busy,
	output logic       print_req,     // strobe, only while printer idle
	output slot_t      req_slot,      // slot that goes with print_req
	output matrix_t    print_mat,
	output logic [1:0] slot_count,    // saturates at NUM_SLOTS
	output logic       activity       // stretched write indicator
);

	matrix_t               slots [NUM_SLOTS];
	slot_t                 wr_ptr;
	slot_t                 pend_slot;     // newest unprinted write
	logic                  pending;
	logic                  issue;
	logic [HOLD_CNT_W-1:0] hold_cnt;

	// ========================================================================
	// ring storage
	// ========================================================================
	always_ff @(posedge clk) begin
		if (parse_done)
			slots[wr_ptr] <= parsed;
	end

	assign print_mat = slots[print_slot];   // combinational read
	assign issue     = pending && !print_busy && !print_req;

	// write pointer, slot count, single pending request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			pend_slot  <= '0;
			pending    <= 1'b0;
			print_req  <= 1'b0;
			req_slot   <= '0;
			slot_count <= '0;
		end else begin
			print_req <= issue;
			if (issue)
				req_slot <= pend_slot;
			if (parse_done) begin
				wr_ptr    <= (wr_ptr == slot_t'(NUM_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
				pend_slot <= wr_ptr;            // newer write replaces the old one
				pending   <= 1'b1;
				if (slot_count != 2'(NUM_SLOTS))
					slot_count <= slot_count + 1'b1;
			end else if (issue) begin
				pending <= 1'b0;
			end
		end
	end

	// ========================================================================
	// activity LED stretch
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			activity <= 1'b0;
			hold_cnt <= '0;
		end else if (parse_done) begin
			activity <= 1'b1;
			hold_cnt <= HOLD_CNT_W'(LED_HOLD_CYCLES - 1);   // restart on each write
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end else begin
			activity <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/matrix_printer.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_printer
	import uart_pkg::*;
	import matrix_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  wire     print_req,
	input  slot_t   print_slot_in,
	input  matrix_t print_mat,       // record at print_slot
	input  wire     tx_busy,
	output slot_t   print_slot,      // latched read address
	output logic    print_busy,
	output logic    tx_en,
	output byte_t   tx_data
);

	typedef enum logic [2:0] {PR_IDLE, PR_DIGIT, PR_SPACE, PR_CR, PR_LF} pr_state_t;

	pr_state_t             state;
	dim_t                  row;
	dim_t                  col;
	logic [ELEM_IDX_W-1:0] elem_idx;    // row-major walk
	logic                  can_send;
	logic                  send;
	byte_t                 next_char;

	// no send right after a tx_en, busy not up yet
	assign can_send   = !tx_busy && !tx_en;
	assign print_busy = (state != PR_IDLE);
	assign send       = print_busy && can_send;

	always_comb begin
		case (state)
			PR_DIGIT: next_char = ASCII_ZERO + print_mat.elems[elem_idx];
			PR_SPACE: next_char = ASCII_SPACE;
			PR_CR:    next_char = ASCII_CR;
			default:  next_char = ASCII_LF;
		endcase
	end

	// ========================================================================
	// text FSM, digits split by spaces, CR LF per row
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= PR_IDLE;
			row        <= '0;
			col        <= '0;
			elem_idx   <= '0;
			print_slot <= '0;
			tx_en      <= 1'b0;
		end else begin
			tx_en <= send;
			case (state)
				PR_IDLE: if (print_req) begin
					print_slot <= print_slot_in;
					row        <= '0;
					col        <= '0;
					elem_idx   <= '0;
					state      <= PR_DIGIT;
				end
				PR_DIGIT: if (send) begin
					elem_idx <= elem_idx + 1'b1;
					if (col == print_mat.cols - 1'b1) begin
						state <= PR_CR;          // end of row
					end else begin
						col   <= col + 1'b1;
						state <= PR_SPACE;
					end
				end
				PR_SPACE: if (send)
					state <= PR_DIGIT;
				PR_CR: if (send)
					state <= PR_LF;
				PR_LF: if (send) begin
					col   <= '0;
					row   <= row + 1'b1;
					state <= (row == print_mat.rows - 1'b1) ? PR_IDLE : PR_DIGIT;
				end
				default: state <= PR_IDLE;
			endcase
		end
	end

	// character register, loaded with each send
	always_ff @(posedge clk) begin
		if (send)
			tx_data <= next_char;
	end

endmodule

`default_nettype wire

/* hw/matrix_entry_top.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_entry_top (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       uart_rxd,
	input  wire       input_en,    // level, enables matrix entry
	output wire       uart_txd,
	output wire [7:0] led
);

	// rx to parser
	logic                rx_done;
	uart_pkg::byte_t     rx_data;
	// parser to store
	logic                parse_done;
	logic                parse_error;
	matrix_pkg::matrix_t parsed;
	// store and printer
	logic                print_req;
	matrix_pkg::slot_t   req_slot;
	matrix_pkg::slot_t   print_slot;
	matrix_pkg::matrix_t print_mat;
	logic                print_busy;
	logic [1:0]          slot_count;
	logic                activity;
	// printer to tx
	logic                tx_en;
	uart_pkg::byte_t     tx_data;
	logic                tx_busy;

	uart_rx u_uart_rx (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd),
		.rx_done(rx_done), .rx_data(rx_data)
	);

	matrix_parser u_parser (
		.clk(clk), .rst_n(rst_n), .input_en(input_en),
		.rx_done(rx_done), .rx_data(rx_data),
		.parse_done(parse_done), .parsed(parsed), .parse_error(parse_error)
	);

	matrix_store u_store (
		.clk(clk), .rst_n(rst_n), .parse_done(parse_done), .parsed(parsed),
		.print_slot(print_slot), .print_busy(print_busy),
		.print_req(print_req), .req_slot(req_slot), .print_mat(print_mat),
		.slot_count(slot_count), .activity(activity)
	);

	matrix_printer u_printer (
		.clk(clk), .rst_n(rst_n), .print_req(print_req), .print_slot_in(req_slot),
		.print_mat(print_mat), .tx_busy(tx_busy), .print_slot(print_slot),
		.print_busy(print_busy), .tx_en(tx_en), .tx_data(tx_data)
	);

	uart_tx u_uart_tx (
		.clk(clk), .rst_n(rst_n), .tx_en(tx_en), .tx_data(tx_data),
		.uart_txd(uart_txd), .tx_busy(tx_busy)
	);

	// activity in bit 0, count in 2..1, error in bit 3
	assign led = {4'b0000, parse_error, slot_count, activity};

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import uart_pkg::*;
	import matrix_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  wire       uart_txd,      // echo line from the DUT
	input  wire [7:0] led,
	output int        pending,       // echo chars still due
	output int        value_errs,    // wrong char or led value
	output int        other_errs     // framing faults, stray chars
);

	byte_t exp_q [$];                // expected echo text, in line order
	string cur_name;
	logic  first_char;               // next start bit opens an echo
	int    char_idx;                 // position inside the echo

	initial begin
		pending    = 0;
		value_errs = 0;
		other_errs = 0;
		first_char = 1'b0;
		char_idx   = 0;
		cur_name   = "reset";
	end

	task automatic begin_test(input string name);
		cur_name = name;
		char_idx = 0;
	endtask

	// echo format: digits split by spaces, CR LF closes each row
	task automatic expect_echo(input matrix_t m);
		int r;
		int c;
		first_char = 1'b1;
		for (r = 0; r < int'(m.rows); r++) begin
			for (c = 0; c < int'(m.cols); c++) begin
				exp_q.push_back(ASCII_ZERO + m.elems[r * int'(m.cols) + c]);
				if (c < int'(m.cols) - 1)
					exp_q.push_back(ASCII_SPACE);     // none after the last column
			end
			exp_q.push_back(ASCII_CR);
			exp_q.push_back(ASCII_LF);
		end
		pending = exp_q.size();
	endtask

	task automatic flush_echo();
		exp_q.delete();
		pending    = 0;
		first_char = 1'b0;
	endtask

	// bit 0 is timing dependent here, checked at echo start instead
	task automatic check_led(input string name, input logic [7:1] exp_bits);
		if (led[7:1] !== exp_bits) begin
			value_errs++;
			$display("Error: %s: led[7:1] expected %b actual %b", name, exp_bits, led[7:1]);
		end
	endtask

	task automatic check_char(input byte_t ch);
		byte_t exp_ch;
		if (exp_q.size() == 0) begin
			other_errs++;
			$display("%s: uart_txd sent 8'h%02h while no echo was due", cur_name, ch);
		end else begin
			exp_ch  = exp_q.pop_front();
			pending = exp_q.size();
			if (ch !== exp_ch) begin
				value_errs++;
				$display("Error: %s: echo char %0d expected 8'h%02h actual 8'h%02h",
				         cur_name, char_idx, exp_ch, ch);
			end
			char_idx++;
		end
	endtask

	// ========================================================================
	// uart_txd decoder, sampled on the falling edge
	// ========================================================================
	initial begin : decode
		byte_t ch;
		int    i;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && uart_txd === 1'b0) begin
				if (first_char) begin
					first_char = 1'b0;
					if (led[0] !== 1'b1) begin     // activity stretch must be up
						value_errs++;
						$display("Error: %s: led[0] at echo start expected 1 actual %b",
						         cur_name, led[0]);
					end
				end
				repeat (HALF_BIT) @(negedge clk);             // mid start bit
				for (i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					ch[i] = uart_txd;                          // lsb first
				end
				repeat (CLKS_PER_BIT) @(negedge clk);         // mid stop bit
				if (uart_txd !== 1'b1) begin
					other_errs++;
					$display("%s: low stop bit on uart_txd", cur_name);
				end else begin
					check_char(ch);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/tb_matrix_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_entry
	import uart_pkg::*;
	import matrix_pkg::*;
();

	// one table row besides name and text
	typedef struct packed {
		logic       en;        // input_en while sending
		logic       echo;      // echo expected
		logic       err;       // led[3] afterwards
		logic [1:0] count;     // led[2:1] afterwards
	} test_flags_t;

	localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT;
	localparam int QUIET_CYCLES = 4 * FRAME_CYCLES;     // a stray echo would show up here

	logic        clk;
	logic        rst_n;
	logic        uart_rxd;
	logic        input_en;
	wire         uart_txd;
	wire  [7:0]  led;
	int          pending;          // echo chars the checker still waits for
	int          value_errs;
	int          other_errs;
	int          tb_fails;         // echo timeouts
	int          limit_cycles;     // watchdog length, 0 while the table is built
	logic [31:0] lfsr;

	// stimulus table
	string       t_name  [$];
	string       t_text  [$];
	test_flags_t t_flags [$];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;     // 100 ns period
	end

	matrix_entry_top uut (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd), .input_en(input_en),
		.uart_txd(uart_txd), .led(led)
	);

	tb_checker chk (
		.clk(clk), .rst_n(rst_n), .uart_txd(uart_txd), .led(led),
		.pending(pending), .value_errs(value_errs), .other_errs(other_errs)
	);

	// galois lfsr, right shift, feedback mask 8020_0003
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// four lfsr bits per digit, folded into 0..9
	function automatic int random_digit();
		logic [3:0] bits;
		int         k;
		for (k = 0; k < 4; k++) begin
			bits[k] = lfsr[0];
			lfsr    = lfsr_next(lfsr);
		end
		return int'(bits) % 10;
	endfunction

	// input format: rows, cols, then elements; anything not a digit skipped
	function automatic matrix_t text_to_matrix(input string s);
		matrix_t m;
		int      n;
		int      i;
		m = '0;
		n = 0;
		for (i = 0; i < s.len(); i++) begin
			if (s[i] >= ASCII_ZERO && s[i] <= ASCII_ZERO + 8'd9) begin
				if (n == 0)
					m.rows = dim_t'(s[i] - ASCII_ZERO);
				else if (n == 1)
					m.cols = dim_t'(s[i] - ASCII_ZERO);
				else if (n - 2 < MAX_ELEMS)
					m.elems[n - 2] = elem_t'(s[i] - ASCII_ZERO);
				n++;
			end
		end
		return m;
	endfunction

	// digits, spaces between them, CR LF per row
	function automatic int echo_length(input matrix_t m);
		return 2 * int'(m.rows) * int'(m.cols) + int'(m.rows);
	endfunction

	// random rows get their elements appended here
	task automatic add_test(input string name, input logic en, input string text,
	                        input logic rnd, input logic echo, input logic err,
	                        input logic [1:0] count);
		string   s;
		matrix_t m;
		int      k;
		s = text;
		if (rnd) begin
			m = text_to_matrix(text);
			for (k = 0; k < int'(m.rows) * int'(m.cols); k++)
				s = $sformatf("%s %0d", s, random_digit());
			s = {s, "\r\n"};
		end
		t_name.push_back(name);
		t_text.push_back(s);
		t_flags.push_back({en, echo, err, count});
	endtask

	// one 8N1 frame on uart_rxd, lsb first
	task automatic send_byte(input byte_t b);
		logic [FRAME_BITS-1:0] frame;
		int                    k;
		frame = {1'b1, b, 1'b0};
		for (k = 0; k < FRAME_BITS; k++) begin
			@(posedge clk);
			uart_rxd <= frame[k];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// watchdog, sized once the table is known
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit_cycles);
		$display("value errors %0d, other failures %0d", value_errs,
		         other_errs + tb_fails + 1);
		$display("tests failed");
		$finish;
	end

	// ========================================================================
	// table and entry loop
	// ========================================================================
	initial begin
		int          i;
		int          k;
		int          total;
		int          waited;
		int          wait_limit;
		string       s;
		matrix_t     m;
		test_flags_t f;
		rst_n        = 1'b0;
		uart_rxd     = 1'b1;     // line idle
		input_en     = 1'b0;
		tb_fails     = 0;
		limit_cycles = 0;
		lfsr         = 32'hfc03_3602;

		//       name              en    text                                 rnd   echo  err   cnt
		add_test("fixed_2x3",      1'b1, "23123456",                          1'b0, 1'b1, 1'b0, 2'd1);
		add_test("input_disabled", 1'b0, "1 1 5",                             1'b0, 1'b0, 1'b0, 2'd1);
		add_test("blanks_inside",  1'b1, "\r\n 2  3\r\n1 2 3\r\n4 5\r\n6 ", 1'b0, 1'b1, 1'b0, 2'd2);
		add_test("bad_char",       1'b1, "2 2 1 x",                           1'b0, 1'b0, 1'b1, 2'd2);
		add_test("random_3x4",     1'b1, "3 4",                               1'b1, 1'b1, 1'b0, 2'd2);
		add_test("dim_zero",       1'b1, "0 ",                                1'b0, 1'b0, 1'b1, 2'd2);
		add_test("dim_six",        1'b1, "2 6 ",                              1'b0, 1'b0, 1'b1, 2'd2);
		add_test("random_5x5",     1'b1, "5 5",                               1'b1, 1'b1, 1'b0, 2'd2);
		add_test("fixed_1x1",      1'b1, "1 1 9\r\n",                         1'b0, 1'b1, 1'b0, 2'd2);

		// every byte on both lines, three times over, plus the quiet gaps
		total = 0;
		for (i = 0; i < t_name.size(); i++) begin
			s      = t_text[i];
			f      = t_flags[i];
			total += s.len();
			if (f.echo)
				total += echo_length(text_to_matrix(s));
		end
		limit_cycles = total * FRAME_CYCLES * 3 + (t_name.size() + 2) * 2 * QUIET_CYCLES;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		chk.check_led("reset", 7'd0);

		for (i = 0; i < t_name.size(); i++) begin
			s = t_text[i];
			f = t_flags[i];
			chk.begin_test(t_name[i]);
			@(posedge clk);
			input_en <= f.en;
			if (f.echo) begin
				m = text_to_matrix(s);
				chk.expect_echo(m);
			end
			for (k = 0; k < s.len(); k++)
				send_byte(s[k]);
			// the last LF ends the echo
			if (f.echo) begin
				wait_limit = (echo_length(m) + 2) * 2 * FRAME_CYCLES;
				waited     = 0;
				while (pending != 0 && waited < wait_limit) begin
					@(posedge clk);
					waited++;
				end
				if (pending != 0) begin
					tb_fails++;
					$display("%s: echo stalled with %0d characters missing", t_name[i], pending);
					chk.flush_echo();
				end
			end
			repeat (QUIET_CYCLES) @(posedge clk);
			@(negedge clk);
			chk.check_led(t_name[i], {4'b0000, f.err, f.count});
		end

		$display("value errors %0d, other failures %0d", value_errs, other_errs + tb_fails);
		if (value_errs == 0 && other_errs + tb_fails == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/uart_pkg.sv
hw/matrix_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/matrix_parser.sv
hw/matrix_store.sv
hw/matrix_printer.sv
hw/matrix_entry_top.sv
bench/tb_checker.sv
bench/tb_matrix_entry.sv

/* Makefile */
# Verilator build for the matrix entry front end

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_matrix_entry
RTL_TOP   ?= matrix_entry_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= all tests passed

SOURCES   := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter hw/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
